// ==== include/trs_io_config.svh ====
`ifndef TRS_IO_CONFIG_SVH
`define TRS_IO_CONFIG_SVH

// identification replies for the ESP
`define TRS_COOKIE            8'hAF
`define TRS_VERSION_MAJOR     3'd0
`define TRS_VERSION_MINOR     5'd3

// z80 port map
`define TRS_PORT_TRSIO        8'h1F
`define TRS_PORT_CASS         8'hFF
`define TRS_PORT_ORCH_L       8'h75
`define TRS_PORT_ORCH_R       8'h79
`define TRS_FREHD_NIBBLE      4'hC
`define TRS_PRINTER_BASE      8'hF8
`define TRS_PRINTER_ALT       8'hF4

// access pipeline, counted in clk cycles after the strobe edge
`define TRS_ADDR_LATCH_DELAY  4
`define TRS_ACCESS_DELAY      8

// length of the request pulse to the ESP
`define TRS_ESP_REQ_CYCLES    50

`endif

// ==== verilog/trs_bus_pkg.sv ====
`default_nettype none

package trs_bus_pkg;

  // port address as latched from the multiplexed bus
  typedef logic [7:0] trs_addr_t;

  // bus data, natural bit order
  typedef logic [7:0] trs_data_t;

  // access code handed to the ESP with each request
  typedef enum logic [2:0] {
    trs_io_in  = 3'd0,
    trs_io_out = 3'd1,
    frehd_in   = 3'd2,
    frehd_out  = 3'd3,
    printer_rd = 3'd4,
    printer_wr = 3'd5
  } esp_access_t;

  // mixed audio sample, range -256..255
  typedef logic signed [8:0] audio_sample_t;

endpackage

`default_nettype wire

// ==== verilog/trs_cmd_pkg.sv ====
`default_nettype none

package trs_cmd_pkg;

  // one byte on the SPI link
  typedef logic [7:0] spi_byte_t;

  // opcodes the card still answers
  // anything else is dropped by the parser
  typedef enum logic [7:0] {
    get_cookie     = 8'd0,
    dbus_read      = 8'd3,
    dbus_write     = 8'd4,
    data_ready     = 8'd5,
    get_version    = 8'd15,
    abus_read      = 8'd18,
    set_esp_status = 8'd32
  } cmd_op_t;

  // waiting for an opcode, or for the single parameter byte
  typedef enum logic {
    idle       = 1'b0,
    read_param = 1'b1
  } parse_state_t;

  // bit 0 is esp ready
  typedef logic [7:0] esp_status_t;

endpackage

`default_nettype wire

// ==== verilog/trs_bus_decoder.sv ====
`include "trs_io_config.svh"

`default_nettype none

module trs_bus_decoder
  import trs_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        z80_in_n,
  input  logic        z80_out_n,
  input  logic        z80_ioreq_n,
  input  logic        esp_ready,
  input  trs_data_t   out_data,
  inout  wire  [7:0]  trs_ad,
  output trs_addr_t   trs_a,
  output trs_data_t   trs_d,
  output logic        io_access,
  output logic        esp_sel,
  output logic        trsio_access,
  output logic        extiosel,
  output logic        abus_sel_n,
  output logic        dbus_sel_n,
  output logic        trs_dir,
  output esp_access_t esp_code,
  output logic        cass_wr,
  output logic        orch_l_wr,
  output logic        orch_r_wr
);

  localparam int latch_stage  = `TRS_ADDR_LATCH_DELAY;
  localparam int access_stage = `TRS_ACCESS_DELAY;
  localparam trs_addr_t printer_base = `TRS_PRINTER_BASE;
  localparam trs_addr_t printer_alt  = `TRS_PRINTER_ALT;

  logic                  trs_in;
  logic                  trs_out;
  logic [2:0]            strobe_sync;
  logic                  strobe_edge;
  logic [access_stage:0] io_trigger;
  logic                  trsio_hit;
  logic                  frehd_hit;
  logic                  trsio_in, trsio_out;
  logic                  frehd_in_sel, frehd_out_sel;
  logic                  printer_rd_sel, printer_wr_sel;
  logic                  esp_sel_in;
  logic                  drive_bus;
  trs_data_t             rd_bus;

  assign trs_in  = ~z80_ioreq_n & ~z80_in_n;
  assign trs_out = ~z80_ioreq_n & ~z80_out_n;

  // two sync flops, the third one only for the edge
  always_ff @(posedge clk) begin
    if (rst) begin
      strobe_sync <= '0;
      io_trigger  <= '0;
    end else begin
      strobe_sync <= {strobe_sync[1:0], trs_in | trs_out};
      io_trigger  <= {io_trigger[access_stage-1:0], strobe_edge};
    end
  end

  assign strobe_edge = strobe_sync[1] & ~strobe_sync[2];
  assign io_access   = io_trigger[access_stage];

  // address phase lasts until the latch stage has passed
  assign abus_sel_n = ~|io_trigger[latch_stage:0];

  always_ff @(posedge clk) begin
    if (io_trigger[latch_stage]) begin
      trs_a <= trs_ad;
    end
  end

  // data lines come in bit-reversed
  assign trs_d = {<<{trs_ad}};

  assign trsio_hit = (trs_a == `TRS_PORT_TRSIO);
  assign frehd_hit = (trs_a[7:4] == `TRS_FREHD_NIBBLE);

  // esp ports only answer once the ESP reports ready
  assign trsio_in      = esp_ready & trsio_hit & trs_in;
  assign trsio_out     = esp_ready & trsio_hit & trs_out;
  assign frehd_in_sel  = esp_ready & frehd_hit & trs_in;
  assign frehd_out_sel = esp_ready & frehd_hit & trs_out;

  // status read is mirrored below the printer at F4..F7
  assign printer_rd_sel = esp_ready & trs_in &
                          ((trs_a[7:2] == printer_base[7:2]) |
                           (trs_a[7:2] == printer_alt[7:2]));
  assign printer_wr_sel = esp_ready & trs_out & (trs_a[7:2] == printer_base[7:2]);

  assign esp_sel_in = trsio_in | frehd_in_sel | printer_rd_sel;
  assign esp_sel    = esp_sel_in | trsio_out | frehd_out_sel | printer_wr_sel;
  assign extiosel   = esp_sel_in;

  // used for clearing the interrupt, not gated by esp ready
  assign trsio_access = trsio_hit & (trs_in | trs_out);

  always_comb begin
    esp_code = trs_io_in;
    if (trsio_out) begin
      esp_code = trs_io_out;
    end else if (frehd_in_sel) begin
      esp_code = frehd_in;
    end else if (frehd_out_sel) begin
      esp_code = frehd_out;
    end else if (printer_rd_sel) begin
      esp_code = printer_rd;
    end else if (printer_wr_sel) begin
      esp_code = printer_wr;
    end
  end

  // data phase after the address is gone
  assign dbus_sel_n = ~(abus_sel_n & (trs_out | esp_sel_in));
  assign trs_dir    = ~trs_in;

  assign rd_bus    = {<<{out_data}};
  assign drive_bus = trs_in & ~dbus_sel_n;
  assign trs_ad    = drive_bus ? rd_bus : 8'bz;

  // audio port writes, one cycle with io_access
  assign cass_wr   = io_access & trs_out & (trs_a == `TRS_PORT_CASS);
  assign orch_l_wr = io_access & trs_out & (trs_a == `TRS_PORT_ORCH_L);
  assign orch_r_wr = io_access & trs_out & (trs_a == `TRS_PORT_ORCH_R);

endmodule

`default_nettype wire

// ==== verilog/spi_command_link.sv ====
`include "trs_io_config.svh"

`default_nettype none

module spi_command_link
  import trs_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      sck,
  input  logic      mosi,
  input  logic      cs_n,
  input  spi_byte_t reply,
  output logic      miso,
  output logic      cmd_valid,
  output cmd_op_t   cmd,
  output spi_byte_t param
);

  logic [2:0]   sck_r;
  logic [2:0]   cs_r;
  logic [1:0]   mosi_r;
  logic         sck_rise;
  logic         sck_fall;
  logic         cs_active;
  logic         cs_start;
  logic [2:0]   bit_cnt;
  spi_byte_t    rx_byte;
  logic         rx_done;
  spi_byte_t    tx_shift;
  parse_state_t state;

  // pins are asynchronous to clk
  always_ff @(posedge clk) begin
    if (rst) begin
      sck_r <= '0;
      cs_r  <= '1;
    end else begin
      sck_r <= {sck_r[1:0], sck};
      cs_r  <= {cs_r[1:0], cs_n};
    end
  end

  always_ff @(posedge clk) begin
    mosi_r <= {mosi_r[0], mosi};
  end

  assign sck_rise  = (sck_r[2:1] == 2'b01);
  assign sck_fall  = (sck_r[2:1] == 2'b10);
  assign cs_active = ~cs_r[1];
  assign cs_start  = (cs_r[2:1] == 2'b10);

  // receive side, msb first on rising sck
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        rx_byte <= {rx_byte[6:0], mosi_r[1]};
        if (bit_cnt == 3'd7) begin
          rx_done <= 1'b1;
        end
      end
    end
  end

  // transmit side
  // reply is loaded at frame start and on the falling edge that opens each byte
  always_ff @(posedge clk) begin
    if (cs_start) begin
      tx_shift <= reply;
    end else if (cs_active && sck_fall) begin
      if (bit_cnt == 3'd0) begin
        tx_shift <= reply;
      end else begin
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
    end
  end

  assign miso = cs_active ? tx_shift[7] : 1'bz;

  // command parser
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= idle;
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (!cs_active) begin
        state <= idle;
      end else if (rx_done) begin
        case (state)
          idle: begin
            case (rx_byte)
              get_cookie, get_version, dbus_read, abus_read, data_ready: begin
                cmd       <= cmd_op_t'(rx_byte);
                cmd_valid <= 1'b1;
              end
              dbus_write, set_esp_status: begin
                cmd   <= cmd_op_t'(rx_byte);
                state <= read_param;
              end
              // dropped opcodes fall through here
              default: state <= idle;
            endcase
          end
          read_param: begin
            param     <= rx_byte;
            cmd_valid <= 1'b1;
            state     <= idle;
          end
          default: state <= idle;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/esp_host_regs.sv ====
`include "trs_io_config.svh"

`default_nettype none

module esp_host_regs
  import trs_bus_pkg::*;
  import trs_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      cmd_valid,
  input  cmd_op_t   cmd,
  input  spi_byte_t param,
  input  trs_addr_t trs_a,
  input  trs_data_t trs_d,
  input  logic      io_access,
  input  logic      esp_sel,
  input  logic      trsio_access,
  input  logic      esp_done,
  output logic      esp_ready,
  output trs_data_t out_data,
  output spi_byte_t reply,
  output logic      esp_req,
  output logic      esp_wait,
  output logic      trs_int
);

  localparam int req_cycles = `TRS_ESP_REQ_CYCLES;
  localparam int count_w    = $clog2(req_cycles + 1);

  esp_status_t        esp_status;
  logic [2:0]         done_r;
  logic               done_rise;
  logic               esp_start;
  logic [count_w-1:0] req_count;

  always_ff @(posedge clk) begin
    if (rst) begin
      esp_status <= '0;
    end else if (cmd_valid && cmd == set_esp_status) begin
      esp_status <= param;
    end
  end

  assign esp_ready = esp_status[0];

  // read data for the z80 and the reply for the next SPI byte
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      case (cmd)
        dbus_write:  out_data <= param;
        get_cookie:  reply    <= `TRS_COOKIE;
        get_version: reply    <= {`TRS_VERSION_MAJOR, `TRS_VERSION_MINOR};
        dbus_read:   reply    <= trs_d;
        abus_read:   reply    <= trs_a;
        default: ;
      endcase
    end
  end

  // done comes from another clock domain
  always_ff @(posedge clk) begin
    if (rst) begin
      done_r <= '0;
    end else begin
      done_r <= {done_r[1:0], esp_done};
    end
  end

  assign done_rise = (done_r[2:1] == 2'b01);
  assign esp_start = io_access & esp_sel;

  // request pulse, restarted by each new access
  always_ff @(posedge clk) begin
    if (rst) begin
      esp_req   <= 1'b0;
      esp_wait  <= 1'b0;
      req_count <= '0;
    end else begin
      if (esp_start) begin
        esp_req   <= 1'b1;
        req_count <= count_w'(req_cycles);
      end else if (req_count == count_w'(1)) begin
        esp_req   <= 1'b0;
        req_count <= '0;
      end else if (req_count != '0) begin
        req_count <= req_count - count_w'(1);
      end

      // z80 is held until the ESP signals done
      if (esp_start) begin
        esp_wait <= 1'b1;
      end else if (done_rise) begin
        esp_wait <= 1'b0;
      end
    end
  end

  // set by data_ready, cleared by the z80 touching port 1F
  always_ff @(posedge clk) begin
    if (rst) begin
      trs_int <= 1'b0;
    end else if (cmd_valid && cmd == data_ready) begin
      trs_int <= 1'b1;
    end else if (io_access && trsio_access) begin
      trs_int <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cass_orch_mixer.sv ====
`include "trs_io_config.svh"

`default_nettype none

module cass_orch_mixer
  import trs_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  trs_data_t trs_d,
  input  logic      cass_wr,
  input  logic      orch_l_wr,
  input  logic      orch_r_wr,
  output logic      cass_out_left,
  output logic      cass_out_right
);

  logic [1:0]    cass_reg;
  trs_data_t     orch_reg [2];
  audio_sample_t sample   [2];
  // bit 9 is the carry out
  logic [9:0]    pdm_acc  [2];

  // cassette level 0..2 shifts the orchestra byte by -128, 0 or +128
  function automatic audio_sample_t mix_sample(trs_data_t orch, logic [1:0] cass);
    logic [1:0] level;
    level = {1'b0, ~cass[1]} + {1'b0, cass[0]};
    return audio_sample_t'({orch[7], orch} + {level - 2'd1, 7'b0});
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      cass_reg <= '0;
      orch_reg <= '{default: '0};
      sample   <= '{default: '0};
      pdm_acc  <= '{default: '0};
    end else begin
      if (cass_wr) begin
        cass_reg <= trs_d[1:0];
      end
      if (orch_l_wr) begin
        orch_reg[0] <= trs_d;
      end
      if (orch_r_wr) begin
        orch_reg[1] <= trs_d;
      end
      for (int ch = 0; ch < 2; ch++) begin
        sample[ch]  <= mix_sample(orch_reg[ch], cass_reg);
        // first order pdm, sample biased to 0..511
        pdm_acc[ch] <= {1'b0, pdm_acc[ch][8:0]} +
                       {1'b0, ~sample[ch][8], sample[ch][7:0]};
      end
    end
  end

  assign cass_out_left  = pdm_acc[0][9];
  assign cass_out_right = pdm_acc[1][9];

endmodule

`default_nettype wire

// ==== verilog/trs_io_top.sv ====
`default_nettype none

module trs_io_top
  import trs_bus_pkg::*;
  import trs_cmd_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        sck,
  input  logic        mosi,
  input  logic        cs_n,
  output logic        miso,
  input  logic        z80_in_n,
  input  logic        z80_out_n,
  input  logic        z80_ioreq_n,
  inout  wire  [7:0]  trs_ad,
  output logic        abus_sel_n,
  output logic        dbus_sel_n,
  output logic        trs_dir,
  output logic        extiosel,
  output logic        trs_int,
  output logic        esp_req,
  output esp_access_t esp_code,
  output logic        esp_wait,
  input  logic        esp_done,
  output logic        cass_out_left,
  output logic        cass_out_right
);

  trs_addr_t trs_a;
  trs_data_t trs_d;
  trs_data_t out_data;
  logic      io_access;
  logic      esp_sel;
  logic      trsio_access;
  logic      esp_ready;
  logic      cass_wr, orch_l_wr, orch_r_wr;
  logic      cmd_valid;
  cmd_op_t   cmd;
  spi_byte_t param;
  spi_byte_t reply;

  trs_bus_decoder trs_bus_decoder_i (
    .clk, .rst, .z80_in_n, .z80_out_n, .z80_ioreq_n, .esp_ready, .out_data,
    .trs_ad, .trs_a, .trs_d, .io_access, .esp_sel, .trsio_access, .extiosel,
    .abus_sel_n, .dbus_sel_n, .trs_dir, .esp_code, .cass_wr, .orch_l_wr, .orch_r_wr
  );

  spi_command_link spi_command_link_i (
    .clk, .rst, .sck, .mosi, .cs_n, .reply, .miso, .cmd_valid, .cmd, .param
  );

  // merges the SPI commands with the bus accesses
  esp_host_regs esp_host_regs_i (
    .clk, .rst, .cmd_valid, .cmd, .param, .trs_a, .trs_d, .io_access, .esp_sel,
    .trsio_access, .esp_done, .esp_ready, .out_data, .reply, .esp_req, .esp_wait,
    .trs_int
  );

  cass_orch_mixer cass_orch_mixer_i (
    .clk, .rst, .trs_d, .cass_wr, .orch_l_wr, .orch_r_wr, .cass_out_left,
    .cass_out_right
  );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== test/trs_io_asserts.sv ====
`include "trs_io_config.svh"

`default_nettype none

module trs_io_asserts (
  input logic clk,
  input logic rst,
  input logic esp_req,
  input logic esp_wait
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_total = 0;

  // wait only comes up together with a fresh request
  wait_with_req: assert property (@(posedge clk) disable iff (rst)
    $rose(esp_wait) |-> $rose(esp_req))
    else begin
      fail_total++;
      $error("esp_wait rose without esp_req rising");
    end

  req_length: assert property (@(posedge clk) disable iff (rst)
    $rose(esp_req) |-> ##[1:`TRS_ESP_REQ_CYCLES] !esp_req)
    else begin
      fail_total++;
      $error("esp_req stayed high too long");
    end

  // handshake lines idle right after reset
  reset_idle: assert property (@(posedge clk) rst |=> (!esp_req && !esp_wait))
    else begin
      fail_total++;
      $error("esp_req or esp_wait high after reset");
    end

endmodule

bind esp_host_regs trs_io_asserts trs_io_asserts_i (.clk, .rst, .esp_req, .esp_wait);

`default_nettype wire

// ==== test/trs_io_tb.sv ====
`default_nettype none

module trs_io_tb
  import trs_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ref_cookie   = 0;
  localparam int ref_version  = 1;
  localparam int ref_bus_read = 2;
  localparam int ref_pdm_ones = 3;
  localparam int ref_echo     = 4;
  localparam int spi_half     = 8;

  // rough cycle budget per test
  localparam int len_reset    = 20;
  localparam int len_ident    = 600;
  localparam int len_gating   = 800;
  localparam int len_codes    = 400;
  localparam int len_readback = 700;
  localparam int len_irq      = 300;
  localparam int len_audio    = 1400;
  localparam int cycle_limit  = (len_reset + len_ident + len_gating + len_codes +
                                 len_readback + len_irq + len_audio) * 12 / 10;

  logic        clk;
  logic        rst;
  logic        sck;
  logic        mosi;
  logic        cs_n;
  logic        miso;
  logic        z80_in_n;
  logic        z80_out_n;
  logic        z80_ioreq_n;
  wire  [7:0]  trs_ad;
  logic        abus_sel_n;
  logic        dbus_sel_n;
  logic        trs_dir;
  logic        extiosel;
  logic        trs_int;
  logic        esp_req;
  esp_access_t esp_code;
  logic        esp_wait;
  logic        esp_done;
  logic        cass_out_left;
  logic        cass_out_right;
  logic [7:0]  bus_drv;
  logic        bus_en;
  // data phase select and direction seen during the last port cycle
  logic        dsel_seen;
  logic        dir_seen;

  int          kind_q [$];
  string       name_q [$];
  logic [15:0] exp_q [$];
  logic [15:0] act_q [$];
  int          tol_q [$];
  int          pushed;
  int          processed;
  int          fail_count;
  int          check_count;
  int          cycle_count;
  int          seed;

  tb_clock_gen tb_clock_gen_i (.clk);

  trs_io_top trs_io_top_i (
    .clk, .rst, .sck, .mosi, .cs_n, .miso, .z80_in_n, .z80_out_n, .z80_ioreq_n,
    .trs_ad, .abus_sel_n, .dbus_sel_n, .trs_dir, .extiosel, .trs_int, .esp_req,
    .esp_code, .esp_wait, .esp_done, .cass_out_left, .cass_out_right
  );

  // z80 side of the multiplexed bus
  assign trs_ad = bus_en ? bus_drv : 8'bz;

  function automatic logic [7:0] reverse_bits(input logic [7:0] v);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[i] = v[7-i];
    end
    return r;
  endfunction

  function automatic logic [15:0] expected_result(input int what, input logic [7:0] a,
                                                  input logic [7:0] b);
    int level;
    int sample;
    // cassette level is inverted bit 1 plus bit 0
    level  = (b[1] ? 0 : 1) + (b[0] ? 1 : 0);
    sample = $signed(a) + (level - 1) * 128;
    case (what)
      ref_cookie:   return 16'h00AF;
      ref_version:  return {8'h00, 3'd0, 5'd3};
      ref_bus_read: return {8'h00, reverse_bits(a)};
      ref_pdm_ones: return 16'(sample + 256);
      default:      return {8'h00, a};
    endcase
  endfunction

  task automatic push_entry(input int kind, input string name, input logic [15:0] exp_v,
                            input logic [15:0] act_v, input int tol);
    kind_q.push_back(kind);
    name_q.push_back(name);
    exp_q.push_back(exp_v);
    act_q.push_back(act_v);
    tol_q.push_back(tol);
    pushed++;
  endtask

  task automatic check_value(input string name, input logic [15:0] exp_v,
                             input logic [15:0] act_v);
    push_entry(0, name, exp_v, act_v, 0);
  endtask

  task automatic check_near(input string name, input logic [15:0] exp_v,
                            input logic [15:0] act_v);
    push_entry(0, name, exp_v, act_v, 2);
  endtask

  task automatic report_problem(input string msg);
    push_entry(1, msg, '0, '0, 0);
  endtask

  task automatic finish_test(input string name);
    push_entry(2, name, '0, '0, 0);
  endtask

  task automatic spi_frame(input logic [7:0] b0, input logic [7:0] b1, input int nbytes,
                           output logic [7:0] last_rx);
    logic [7:0] tx;
    @(negedge clk);
    cs_n = 1'b0;
    repeat (spi_half) @(negedge clk);
    for (int n = 0; n < nbytes; n++) begin
      tx = (n == 0) ? b0 : b1;
      for (int i = 7; i >= 0; i--) begin
        mosi = tx[i];
        repeat (spi_half) @(negedge clk);
        last_rx[i] = miso;
        sck = 1'b1;
        repeat (spi_half) @(negedge clk);
        sck = 1'b0;
      end
    end
    repeat (spi_half) @(negedge clk);
    cs_n = 1'b1;
    repeat (spi_half) @(negedge clk);
  endtask

  // one z80 port cycle, address until abus_sel_n rises, then data
  task automatic port_cycle(input logic is_in, input logic [7:0] addr, input logic [7:0] data,
                            input string name, output logic saw_req, output logic [2:0] code,
                            output logic sel, output logic [7:0] rd_bus);
    int n;
    @(negedge clk);
    bus_drv     = addr;
    bus_en      = 1'b1;
    z80_ioreq_n = 1'b0;
    if (is_in) begin
      z80_in_n = 1'b0;
    end else begin
      z80_out_n = 1'b0;
    end
    n = 0;
    while (abus_sel_n && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (abus_sel_n) begin
      report_problem({name, ": abus_sel_n never went low"});
    end
    n = 0;
    while (!abus_sel_n && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!abus_sel_n) begin
      report_problem({name, ": abus_sel_n never went high again"});
    end
    if (is_in) begin
      bus_en = 1'b0;
    end else begin
      bus_drv = reverse_bits(data);
    end
    n = 0;
    while (!esp_req && n < 8) begin
      @(negedge clk);
      n++;
    end
    saw_req   = esp_req;
    code      = esp_code;
    sel       = extiosel;
    rd_bus    = trs_ad;
    dsel_seen = dbus_sel_n;
    dir_seen  = trs_dir;
    if (saw_req) begin
      if (!esp_wait) begin
        report_problem({name, ": esp_wait not raised with esp_req"});
      end
      esp_done = 1'b1;
      n = 0;
      while (esp_wait && n < 8) begin
        @(negedge clk);
        n++;
      end
      if (esp_wait) begin
        report_problem({name, ": esp_wait did not fall after esp_done"});
      end
      esp_done = 1'b0;
    end
    z80_ioreq_n = 1'b1;
    z80_in_n    = 1'b1;
    z80_out_n   = 1'b1;
    n = 0;
    while (esp_req && n < 60) begin
      @(negedge clk);
      n++;
    end
    if (esp_req) begin
      report_problem({name, ": esp_req never ended"});
    end
    repeat (6) @(negedge clk);
  endtask

  initial begin : compare_proc
    int          kind;
    string       name;
    logic [15:0] exp_v;
    logic [15:0] act_v;
    int          tol;
    int          diff;
    int          test_checks;
    int          test_fails;
    test_checks = 0;
    test_fails  = 0;
    forever begin
      wait (kind_q.size() != 0);
      kind  = kind_q.pop_front();
      name  = name_q.pop_front();
      exp_v = exp_q.pop_front();
      act_v = act_q.pop_front();
      tol   = tol_q.pop_front();
      if (kind == 0) begin
        check_count++;
        test_checks++;
        diff = int'(act_v) - int'(exp_v);
        if ($isunknown(act_v) || diff > tol || diff < -tol) begin
          $display("ERR %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
          fail_count++;
          test_fails++;
        end
      end else if (kind == 1) begin
        $display("error: %s", name);
        fail_count++;
        test_fails++;
      end else begin
        $display("test %s: %0d checks, %0d failed", name, test_checks, test_fails);
        test_checks = 0;
        test_fails  = 0;
      end
      processed++;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("run stopped after %0d cycles, the tests did not finish", cycle_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin : stimulus
    logic [7:0] rx;
    logic       req;
    logic [2:0] code;
    logic       sel;
    logic [7:0] rd;
    logic [7:0] cass_v;
    logic [7:0] orch_l;
    logic [7:0] orch_r;
    int         ones_l;
    int         ones_r;
    int         total_fail;
    logic [7:0] code_ports [4];
    logic [2:0] code_exp [4];
    code_ports  = '{8'h1F, 8'hC4, 8'hFA, 8'h80};
    code_exp    = '{3'd1, 3'd3, 3'd5, 3'd0};
    rst         = 1'b1;
    sck         = 1'b0;
    mosi        = 1'b0;
    cs_n        = 1'b1;
    z80_in_n    = 1'b1;
    z80_out_n   = 1'b1;
    z80_ioreq_n = 1'b1;
    esp_done    = 1'b0;
    bus_drv     = '0;
    bus_en      = 1'b0;
    seed        = 54;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    spi_frame(8'h00, 8'h00, 2, rx);
    check_value("cookie", expected_result(ref_cookie, 0, 0), {8'h00, rx});
    spi_frame(8'h0F, 8'h00, 2, rx);
    check_value("version", expected_result(ref_version, 0, 0), {8'h00, rx});
    finish_test("ident");

    // ESP not ready yet
    port_cycle(1'b1, 8'h1F, 8'h00, "gate_off", req, code, sel, rd);
    check_value("gate_off_req", 0, req);
    check_value("gate_off_extiosel", 0, sel);
    check_value("gate_off_dbus_sel_n", 1, dsel_seen);
    spi_frame(8'h04, 8'hD2, 2, rx);
    spi_frame(8'h20, 8'h01, 2, rx);
    port_cycle(1'b1, 8'h1F, 8'h00, "gate_on", req, code, sel, rd);
    check_value("gate_on_req", 1, req);
    check_value("gate_on_code", trs_io_in, code);
    check_value("gate_on_extiosel", 1, sel);
    check_value("gate_on_dbus_sel_n", 0, dsel_seen);
    // direction low while the card answers a read
    check_value("gate_on_dir", 0, dir_seen);
    check_value("gate_on_read", expected_result(ref_bus_read, 8'hD2, 0), rd);
    finish_test("gating");

    for (int i = 0; i < 4; i++) begin
      port_cycle(1'b0, code_ports[i], 8'h00, $sformatf("codes_%h", code_ports[i]),
                 req, code, sel, rd);
      check_value($sformatf("codes_%h_req", code_ports[i]), (i < 3), req);
      check_value($sformatf("codes_%h_dir", code_ports[i]), 1, dir_seen);
      if (i < 3) begin
        check_value($sformatf("codes_%h_code", code_ports[i]), code_exp[i], code);
      end
    end
    finish_test("codes");

    // master keeps the data on the bus after the OUT
    port_cycle(1'b0, 8'h1F, 8'h6B, "readback", req, code, sel, rd);
    spi_frame(8'h12, 8'h00, 2, rx);
    check_value("abus_read", expected_result(ref_echo, 8'h1F, 0), {8'h00, rx});
    spi_frame(8'h03, 8'h00, 2, rx);
    check_value("dbus_read", expected_result(ref_echo, 8'h6B, 0), {8'h00, rx});
    finish_test("readback");

    spi_frame(8'h05, 8'h00, 1, rx);
    check_value("irq_set", 1, trs_int);
    port_cycle(1'b0, 8'h1F, 8'h11, "irq_clear", req, code, sel, rd);
    check_value("irq_clear", 0, trs_int);
    finish_test("irq");

    cass_v = $random(seed);
    orch_l = $random(seed);
    orch_r = $random(seed);
    port_cycle(1'b0, 8'hFF, cass_v, "audio_cass", req, code, sel, rd);
    check_value("audio_cass_req", 0, req);
    port_cycle(1'b0, 8'h75, orch_l, "audio_left", req, code, sel, rd);
    port_cycle(1'b0, 8'h79, orch_r, "audio_right", req, code, sel, rd);
    repeat (8) @(negedge clk);
    ones_l = 0;
    ones_r = 0;
    for (int i = 0; i < 512; i++) begin
      @(negedge clk);
      ones_l += cass_out_left;
      ones_r += cass_out_right;
    end
    check_near("pdm_left", expected_result(ref_pdm_ones, orch_l, cass_v), 16'(ones_l));
    check_near("pdm_right", expected_result(ref_pdm_ones, orch_r, cass_v), 16'(ones_r));
    finish_test("audio");

    wait (processed == pushed);
    total_fail = fail_count + trs_io_top_i.esp_host_regs_i.trs_io_asserts_i.fail_total;
    $display("checks: %0d, failed: %0d", check_count, total_fail);
    if (total_fail == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
verilog/trs_bus_pkg.sv
verilog/trs_cmd_pkg.sv
verilog/trs_bus_decoder.sv
verilog/spi_command_link.sv
verilog/esp_host_regs.sv
verilog/cass_orch_mixer.sv
verilog/trs_io_top.sv
test/tb_clock_gen.sv
test/trs_io_asserts.sv
test/trs_io_tb.sv
